/* verilog/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    localparam int ADDR_BITS        = 32;
    localparam int BYTE_BITS        = 3;   // byte within a 64-bit word
    localparam int OFFSET_BITS      = 3;   // word within a line
    localparam int INDEX_BITS       = 4;
    localparam int LINE_OFFSET_BITS = OFFSET_BITS + BYTE_BITS;
    localparam int TAG_BITS         = ADDR_BITS - INDEX_BITS - LINE_OFFSET_BITS;
    localparam int WORDS_PER_LINE   = 1 << OFFSET_BITS;
    localparam int NUM_SETS         = 1 << INDEX_BITS;
    localparam int NUM_WAYS         = 2;
    localparam int WAY_BITS         = $clog2(NUM_WAYS);

    localparam logic [7:0] LFSR_SEED = 8'ha5;

    typedef logic [ADDR_BITS-1:0]   addr_t;
    typedef logic [63:0]            word_t;
    typedef logic [INDEX_BITS-1:0]  index_t;
    typedef logic [OFFSET_BITS-1:0] offset_t;
    typedef logic [TAG_BITS-1:0]    tag_t;
    typedef logic [WAY_BITS-1:0]    way_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        UPDATE,
        RESPOND
    } dcache_state_e;

endpackage

`default_nettype wire

/* verilog/tbus_pkg.sv */
`default_nettype none

package tbus_pkg;

    localparam int TBUS_WORD_BITS  = 64;
    localparam int TBUS_LINE_WORDS = 8;

    typedef enum logic {
        TBUS_READ  = 1'b0,
        TBUS_WRITE = 1'b1
    } tbus_op_e;

    // one cache line with word 0 in the low bits
    typedef logic [TBUS_LINE_WORDS-1:0][TBUS_WORD_BITS-1:0] line_t;

endpackage

`default_nettype wire

/* verilog/dcache_tag_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface dcache_tag_if;
    import dcache_pkg::*;

    logic                       ce;        // read strobe
    logic                       we;
    index_t                     index;
    logic [NUM_WAYS-1:0]        way_sel;   // one-hot
    tag_entry_t                 wentry;
    tag_entry_t [NUM_WAYS-1:0]  rentries;  // valid the cycle after ce

    modport ctrl (
        output ce, we, index, way_sel, wentry,
        input  rentries
    );

    modport array (
        input  ce, we, index, way_sel, wentry,
        output rentries
    );

endinterface

`default_nettype wire

/* verilog/dcache_data_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface dcache_data_if;
    import dcache_pkg::*;
    import tbus_pkg::*;

    logic                   ce;
    logic                   we;
    index_t                 index;
    logic [NUM_WAYS-1:0]    way_sel;
    line_t                  wline;
    line_t                  wmask;   // bit mask over the whole line
    line_t [NUM_WAYS-1:0]   rlines;

    modport ctrl (
        output ce, we, index, way_sel, wline, wmask,
        input  rlines
    );

    modport array (
        input  ce, we, index, way_sel, wline, wmask,
        output rlines
    );

endinterface

`default_nettype wire

/* verilog/dcache_tag_array.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_tag_array (
    input wire          clock,
    input wire          reset_n,
    dcache_tag_if.array tag
);
    import dcache_pkg::*;

    logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
    tag_entry_t          entry_q [NUM_SETS][NUM_WAYS];  // dirty and tag used from here

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else if (tag.we) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (tag.way_sel[w]) begin
                    valid_q[tag.index][w] <= tag.wentry.valid;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (tag.we && tag.way_sel[w]) begin
                entry_q[tag.index][w] <= tag.wentry;
            end
            if (tag.ce) begin
                tag.rentries[w] <= '{valid: valid_q[tag.index][w],
                                     dirty: entry_q[tag.index][w].dirty,
                                     tag:   entry_q[tag.index][w].tag};
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/dcache_data_array.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_data_array (
    input wire           clock,
    dcache_data_if.array data
);
    import dcache_pkg::*;
    import tbus_pkg::*;

    line_t lines_q [NUM_SETS][NUM_WAYS];

    always_ff @(posedge clock) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (data.we && data.way_sel[w]) begin
                // only masked bits change
                lines_q[data.index][w] <= (lines_q[data.index][w] & ~data.wmask)
                                        | (data.wline & data.wmask);
            end
            if (data.ce) begin
                data.rlines[w] <= lines_q[data.index][w];
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/dcache_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_ctrl (
    input  wire                     clock,
    input  wire                     reset_n,

    input  wire                     req_valid,
    output logic                    req_ready,
    input  wire tbus_pkg::tbus_op_e req_op,
    input  wire dcache_pkg::addr_t  req_addr,
    input  wire dcache_pkg::word_t  req_wdata,
    input  wire dcache_pkg::word_t  req_wmask,
    output logic                    resp_done,
    output dcache_pkg::word_t       resp_rdata,

    output logic                    mem_valid,
    input  wire                     mem_ready,
    output tbus_pkg::tbus_op_e      mem_op,
    output dcache_pkg::addr_t       mem_addr,
    output tbus_pkg::line_t         mem_wline,
    input  wire                     mem_done,
    input  wire tbus_pkg::line_t    mem_rline,

    dcache_tag_if.ctrl              tag,
    dcache_data_if.ctrl             data
);
    import dcache_pkg::*;
    import tbus_pkg::*;

    dcache_state_e state_q;
    logic          mem_valid_q;
    logic [7:0]    lfsr_q;

    // registered request and miss context
    tbus_op_e op_q;
    addr_t    addr_q;
    word_t    wdata_q;
    word_t    wmask_q;
    word_t    rdata_q;
    way_t     victim_q;
    addr_t    wb_addr_q;
    line_t    wb_line_q;
    line_t    line_q;      // refill line with the store merged

    tag_t    req_tag;
    index_t  req_index;
    offset_t req_word;
    addr_t   req_line_addr;

    logic hit;
    way_t hit_way;
    logic found_free;
    way_t free_way;
    way_t victim;
    logic victim_dirty;

    line_t store_mask;
    line_t store_line;
    line_t refill_merged;

    assign req_tag       = addr_q[ADDR_BITS-1 -: TAG_BITS];
    assign req_index     = addr_q[LINE_OFFSET_BITS +: INDEX_BITS];
    assign req_word      = addr_q[BYTE_BITS +: OFFSET_BITS];
    assign req_line_addr = {req_tag, req_index, {LINE_OFFSET_BITS{1'b0}}};

    // tag compare and first free way
    always_comb begin
        hit        = 1'b0;
        hit_way    = '0;
        found_free = 1'b0;
        free_way   = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (tag.rentries[w].valid && tag.rentries[w].tag == req_tag) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
            if (!tag.rentries[w].valid && !found_free) begin
                found_free = 1'b1;
                free_way   = way_t'(w);
            end
        end
    end

    assign victim       = found_free ? free_way : lfsr_q[WAY_BITS-1:0];
    assign victim_dirty = tag.rentries[victim].valid && tag.rentries[victim].dirty;

    // store word at its offset with an all-zero mask for loads
    always_comb begin
        store_mask = '0;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            if (op_q == TBUS_WRITE && w == int'(req_word)) begin
                store_mask[w] = wmask_q;
            end
        end
    end

    assign store_line    = {WORDS_PER_LINE{wdata_q}};
    assign refill_merged = (mem_rline & ~store_mask) | (store_line & store_mask);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state_q     <= IDLE;
            mem_valid_q <= 1'b0;
            lfsr_q      <= LFSR_SEED;
        end else begin
            lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
            if (mem_valid_q && mem_ready) begin
                mem_valid_q <= 1'b0;   // accepted by memory
            end
            case (state_q)
                IDLE: begin
                    if (req_valid) begin
                        state_q <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (hit) begin
                        state_q <= RESPOND;
                    end else begin
                        mem_valid_q <= 1'b1;
                        state_q     <= victim_dirty ? WRITEBACK : REFILL;
                    end
                end
                WRITEBACK: begin
                    if (mem_done) begin
                        mem_valid_q <= 1'b1;   // start the line read
                        state_q     <= REFILL;
                    end
                end
                REFILL: begin
                    if (mem_done) begin
                        state_q <= UPDATE;
                    end
                end
                UPDATE:  state_q <= RESPOND;
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        case (state_q)
            IDLE: begin
                if (req_valid) begin
                    op_q    <= req_op;
                    addr_q  <= req_addr;
                    wdata_q <= req_wdata;
                    wmask_q <= req_wmask;
                end
            end
            LOOKUP: begin
                rdata_q   <= data.rlines[hit_way][req_word];
                victim_q  <= victim;
                wb_addr_q <= {tag.rentries[victim].tag, req_index, {LINE_OFFSET_BITS{1'b0}}};
                wb_line_q <= data.rlines[victim];
            end
            REFILL: begin
                if (mem_done) begin
                    line_q  <= refill_merged;
                    rdata_q <= mem_rline[req_word];
                end
            end
            default: ;
        endcase
    end

    // array strobes
    always_comb begin
        tag.ce       = 1'b0;
        tag.we       = 1'b0;
        tag.index    = req_index;
        tag.way_sel  = '0;
        tag.wentry   = '0;
        data.ce      = 1'b0;
        data.we      = 1'b0;
        data.index   = req_index;
        data.way_sel = '0;
        data.wline   = store_line;
        data.wmask   = store_mask;
        case (state_q)
            IDLE: begin
                tag.ce     = req_valid;
                data.ce    = req_valid;
                tag.index  = req_addr[LINE_OFFSET_BITS +: INDEX_BITS];
                data.index = req_addr[LINE_OFFSET_BITS +: INDEX_BITS];
            end
            LOOKUP: begin
                if (hit && op_q == TBUS_WRITE) begin
                    tag.we                = 1'b1;
                    data.we               = 1'b1;
                    tag.way_sel[hit_way]  = 1'b1;
                    data.way_sel[hit_way] = 1'b1;
                    tag.wentry            = '{valid: 1'b1, dirty: 1'b1, tag: req_tag};
                end
            end
            UPDATE: begin
                tag.we                 = 1'b1;
                data.we                = 1'b1;
                tag.way_sel[victim_q]  = 1'b1;
                data.way_sel[victim_q] = 1'b1;
                tag.wentry  = '{valid: 1'b1, dirty: op_q == TBUS_WRITE, tag: req_tag};
                data.wline  = line_q;
                data.wmask  = '1;      // whole line
            end
            default: ;
        endcase
    end

    assign req_ready  = (state_q == IDLE);
    assign resp_done  = (state_q == RESPOND);
    assign resp_rdata = (resp_done && op_q == TBUS_READ) ? rdata_q : '0;

    assign mem_valid = mem_valid_q;
    assign mem_op    = (state_q == WRITEBACK) ? TBUS_WRITE : TBUS_READ;
    assign mem_addr  = (state_q == WRITEBACK) ? wb_addr_q : req_line_addr;
    assign mem_wline = wb_line_q;

endmodule

`default_nettype wire

/* verilog/dcache.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache (
    input  wire                     clock,
    input  wire                     reset_n,

    // core side
    input  wire                     req_valid,
    output logic                    req_ready,
    input  wire tbus_pkg::tbus_op_e req_op,
    input  wire dcache_pkg::addr_t  req_addr,
    input  wire dcache_pkg::word_t  req_wdata,
    input  wire dcache_pkg::word_t  req_wmask,
    output logic                    resp_done,
    output dcache_pkg::word_t       resp_rdata,

    // memory side
    output logic                    mem_valid,
    input  wire                     mem_ready,
    output tbus_pkg::tbus_op_e      mem_op,
    output dcache_pkg::addr_t       mem_addr,
    output tbus_pkg::line_t         mem_wline,
    input  wire                     mem_done,
    input  wire tbus_pkg::line_t    mem_rline
);

    dcache_tag_if  tag_if0 ();
    dcache_data_if data_if0 ();

    dcache_ctrl ctrl0 (
        .clock      (clock),
        .reset_n    (reset_n),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_op     (req_op),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_wmask  (req_wmask),
        .resp_done  (resp_done),
        .resp_rdata (resp_rdata),
        .mem_valid  (mem_valid),
        .mem_ready  (mem_ready),
        .mem_op     (mem_op),
        .mem_addr   (mem_addr),
        .mem_wline  (mem_wline),
        .mem_done   (mem_done),
        .mem_rline  (mem_rline),
        .tag        (tag_if0.ctrl),
        .data       (data_if0.ctrl)
    );

    dcache_tag_array tag_array0 (
        .clock   (clock),
        .reset_n (reset_n),
        .tag     (tag_if0.array)
    );

    dcache_data_array data_array0 (
        .clock (clock),
        .data  (data_if0.array)
    );

endmodule

`default_nettype wire

/* tb/tb_mem_model.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_mem_model (
    input  wire                     clock,
    input  wire                     reset_n,
    input  wire                     mem_valid,
    output logic                    mem_ready,
    input  wire tbus_pkg::tbus_op_e mem_op,
    input  wire dcache_pkg::addr_t  mem_addr,
    input  wire tbus_pkg::line_t    mem_wline,
    output logic                    mem_done,
    output tbus_pkg::line_t         mem_rline
);
    import dcache_pkg::*;
    import tbus_pkg::*;

    line_t  lines [addr_t];   // written lines by line address
    integer seed;

    // untouched memory reads as a fixed function of the byte address
    function automatic word_t fill_word(input addr_t addr);
        return {addr ^ 32'h6b8b_4567, ~addr + 32'h327b_23c6};
    endfunction

    function automatic line_t read_line(input addr_t base);
        line_t line;
        if (lines.exists(base)) begin
            return lines[base];
        end
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            line[w] = fill_word(base + addr_t'(w << BYTE_BITS));
        end
        return line;
    endfunction

    initial begin
        tbus_op_e    op;
        addr_t       addr;
        logic [31:0] r;
        int          latency;
        seed      = 32'h0338fe37;
        mem_ready <= 1'b0;
        mem_done  <= 1'b0;
        mem_rline <= '0;
        forever begin
            @(posedge clock);
            if (reset_n && mem_valid) begin
                r = $random(seed);
                repeat (int'(r[1:0])) @(posedge clock);   // back-pressure
                mem_ready <= 1'b1;
                @(posedge clock);                         // handshake edge
                mem_ready <= 1'b0;
                op   = mem_op;
                addr = mem_addr;
                if (op == TBUS_WRITE) begin
                    lines[addr] = mem_wline;
                end
                latency = 1 + int'(r[4:2]) % 6;
                repeat (latency - 1) @(posedge clock);
                mem_done <= 1'b1;
                if (op == TBUS_READ) begin
                    mem_rline <= read_line(addr);
                end
                @(posedge clock);
                mem_done <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* tb/tb_dcache.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_dcache;
    import dcache_pkg::*;
    import tbus_pkg::*;

    localparam int NUM_REQS     = 600;
    localparam int RESET_CYCLES = 10;
    localparam int MISS_CYCLES  = 40;   // worst-case miss plus request gap
    localparam int TIMEOUT_NS   = (NUM_REQS * MISS_CYCLES + RESET_CYCLES) * 4;

    logic     clock;
    logic     reset_n;
    logic     req_valid;
    logic     req_ready;
    tbus_op_e req_op;
    addr_t    req_addr;
    word_t    req_wdata;
    word_t    req_wmask;
    logic     resp_done;
    word_t    resp_rdata;
    logic     mem_valid;
    logic     mem_ready;
    tbus_op_e mem_op;
    addr_t    mem_addr;
    line_t    mem_wline;
    logic     mem_done;
    line_t    mem_rline;

    integer   seed;
    word_t    ref_mem [addr_t];   // stored words by word address
    tag_t     tag_pool [4];
    index_t   index_pool [4];

    dcache dut0 (
        .clock      (clock),
        .reset_n    (reset_n),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_op     (req_op),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_wmask  (req_wmask),
        .resp_done  (resp_done),
        .resp_rdata (resp_rdata),
        .mem_valid  (mem_valid),
        .mem_ready  (mem_ready),
        .mem_op     (mem_op),
        .mem_addr   (mem_addr),
        .mem_wline  (mem_wline),
        .mem_done   (mem_done),
        .mem_rline  (mem_rline)
    );

    tb_mem_model mem0 (
        .clock     (clock),
        .reset_n   (reset_n),
        .mem_valid (mem_valid),
        .mem_ready (mem_ready),
        .mem_op    (mem_op),
        .mem_addr  (mem_addr),
        .mem_wline (mem_wline),
        .mem_done  (mem_done),
        .mem_rline (mem_rline)
    );

    initial clock = 1'b0;
    always #2 clock = ~clock;

    function automatic word_t lookup_word(input addr_t addr);
        addr_t waddr;
        waddr = {addr[ADDR_BITS-1:BYTE_BITS], {BYTE_BITS{1'b0}}};
        if (ref_mem.exists(waddr)) begin
            return ref_mem[waddr];
        end
        return mem0.fill_word(waddr);   // same fill as the memory side
    endfunction

    function automatic line_t expected_line(input addr_t addr);
        line_t line;
        addr_t base;
        base = {addr[ADDR_BITS-1:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}};
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            line[w] = lookup_word(base + addr_t'(w << BYTE_BITS));
        end
        return line;
    endfunction

    task automatic apply_store(input addr_t addr, input word_t wdata, input word_t wmask);
        addr_t waddr;
        waddr = {addr[ADDR_BITS-1:BYTE_BITS], {BYTE_BITS{1'b0}}};
        ref_mem[waddr] = (lookup_word(addr) & ~wmask) | (wdata & wmask);
    endtask

    task automatic check_word(input string what, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("Error: %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_line(input string what, input line_t actual, input line_t expected);
        if (actual !== expected) begin
            $display("Error: %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string what, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("Error: %0t ns: %s is %b, expected %b", $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // memory bus monitor for writeback data
    always @(posedge clock) begin
        if (reset_n && mem_valid && mem_ready) begin
            check_flag("mem_addr line aligned", mem_addr[LINE_OFFSET_BITS-1:0] == '0, 1'b1);
            if (mem_op == TBUS_WRITE) begin
                check_line("writeback line", mem_wline, expected_line(mem_addr));
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Simulation failed");
        $fatal(1);
    end

    initial begin
        tbus_op_e    op;
        addr_t       addr;
        addr_t       prev_addr;
        word_t       wdata;
        word_t       wmask;
        logic [31:0] r;
        logic        have_prev;
        logic        same_line;
        logic        flag;
        logic        saw_mem;
        int          cycles;
        seed          = 32'h0338fe37;
        tag_pool[0]   = 22'h000000;
        tag_pool[1]   = 22'h000001;
        tag_pool[2]   = 22'h15a5a5;
        tag_pool[3]   = 22'h3fffff;
        index_pool[0] = 4'h0;
        index_pool[1] = 4'h5;
        index_pool[2] = 4'ha;
        index_pool[3] = 4'hf;
        have_prev     = 1'b0;
        prev_addr     = '0;
        reset_n   <= 1'b0;
        req_valid <= 1'b0;
        req_op    <= TBUS_READ;
        req_addr  <= '0;
        req_wdata <= '0;
        req_wmask <= '0;
        repeat (RESET_CYCLES) @(posedge clock);
        reset_n <= 1'b1;
        @(posedge clock);
        check_flag("req_ready after reset", req_ready, 1'b1);
        check_flag("resp_done after reset", resp_done, 1'b0);
        check_flag("mem_valid after reset", mem_valid, 1'b0);

        for (int n = 0; n < NUM_REQS; n++) begin
            r = $random(seed);
            repeat (int'(r[1:0])) begin
                @(posedge clock);
                check_flag("resp_done while idle", resp_done, 1'b0);
            end
            r = $random(seed);
            if (have_prev && r[1:0] == 2'b00) begin
                addr = {prev_addr[ADDR_BITS-1:LINE_OFFSET_BITS], r[8:6], 3'b000};
            end else begin
                addr = {tag_pool[r[3:2]], index_pool[r[5:4]], r[8:6], 3'b000};
            end
            op    = r[9] ? TBUS_WRITE : TBUS_READ;
            wdata = {$random(seed), $random(seed)};
            if (r[10]) begin
                wmask = '1;
            end else begin
                wmask = {$random(seed), $random(seed)};
            end
            same_line = have_prev && addr[ADDR_BITS-1:LINE_OFFSET_BITS]
                                     == prev_addr[ADDR_BITS-1:LINE_OFFSET_BITS];
            req_valid <= 1'b1;
            req_op    <= op;
            req_addr  <= addr;
            req_wdata <= wdata;
            req_wmask <= wmask;

            flag = 1'b0;
            while (!flag) begin
                @(posedge clock);
                check_flag("resp_done while idle", resp_done, 1'b0);
                flag = req_ready;   // accepted on this edge
            end
            req_valid <= 1'b0;
            req_addr  <= $random(seed);   // request must already be registered
            req_wdata <= {$random(seed), $random(seed)};

            cycles  = 0;
            saw_mem = 1'b0;
            flag    = 1'b0;
            while (!flag) begin
                @(posedge clock);
                cycles++;
                saw_mem = saw_mem | mem_valid;
                check_flag("req_ready while busy", req_ready, 1'b0);
                flag = resp_done;
            end

            if (op == TBUS_READ) begin
                check_word("load data", resp_rdata, lookup_word(addr));
            end else begin
                check_word("store resp_rdata", resp_rdata, '0);
                apply_store(addr, wdata, wmask);
            end
            if (same_line) begin
                check_flag("hit done two cycles after accept", cycles == 2, 1'b1);
                check_flag("mem_valid during hit", saw_mem, 1'b0);
            end
            prev_addr = addr;
            have_prev = 1'b1;
        end

        @(posedge clock);
        check_flag("resp_done after last response", resp_done, 1'b0);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
verilog/dcache_pkg.sv
verilog/tbus_pkg.sv
verilog/dcache_tag_if.sv
verilog/dcache_data_if.sv
verilog/dcache_tag_array.sv
verilog/dcache_data_array.sv
verilog/dcache_ctrl.sv
verilog/dcache.sv
tb/tb_mem_model.sv
tb/tb_dcache.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the dcache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_dcache -f sim.f

# exit status is nonzero when the testbench ends in $fatal
./obj_dir/Vtb_dcache
